// ==== design/csi_rx_pkg.sv ====
package csi_rx_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Link constants
  ////////////////////////////////////////////////////////////////////////////

  localparam int NUM_LANES  = 2;
  localparam int FIFO_DEPTH = 4;                 // Covers up to 3 bytes of lane skew.
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

  ////////////////////////////////////////////////////////////////////////////
  // Width types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [7:0]  byte_t;
  typedef logic [15:0] word_t;                   // Lane 0 in the low byte.
  typedef logic [2:0]  bit_ofs_t;
  typedef logic [5:0]  data_type_t;
  typedef logic [1:0]  vc_t;
  typedef logic [15:0] word_cnt_t;
  typedef logic [5:0]  ecc_t;

  localparam byte_t      SYNC_BYTE    = 8'hB8;   // Sent LSB first.
  localparam data_type_t SHORT_DT_MAX = 6'h0F;   // Above this is a long packet.

  typedef enum logic [2:0] {
    IDLE,
    HDR0,
    HDR1,
    PAYLOAD,
    FOOTER,
    DONE
  } parser_state_t;

  ////////////////////////////////////////////////////////////////////////////
  // CSI-2 header ECC
  ////////////////////////////////////////////////////////////////////////////

  // Header bits are {wc_hi, wc_lo, data_id}, data_id in bits 7:0.
  function automatic ecc_t csi_ecc(input logic [23:0] d);
    ecc_t p;
    p[0] = d[0] ^ d[1] ^ d[2] ^ d[4] ^ d[5] ^ d[7] ^ d[10] ^ d[11] ^ d[13] ^
           d[16] ^ d[20] ^ d[21] ^ d[22] ^ d[23];
    p[1] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6] ^ d[8] ^ d[10] ^ d[12] ^ d[14] ^
           d[17] ^ d[20] ^ d[21] ^ d[22] ^ d[23];
    p[2] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6] ^ d[9] ^ d[11] ^ d[12] ^ d[15] ^
           d[18] ^ d[20] ^ d[21] ^ d[22];
    p[3] = d[1] ^ d[2] ^ d[3] ^ d[7] ^ d[8] ^ d[9] ^ d[13] ^ d[14] ^ d[15] ^
           d[19] ^ d[20] ^ d[21] ^ d[23];
    p[4] = d[4] ^ d[5] ^ d[6] ^ d[7] ^ d[8] ^ d[9] ^ d[16] ^ d[17] ^ d[18] ^
           d[19] ^ d[20] ^ d[22] ^ d[23];
    p[5] = d[10] ^ d[11] ^ d[12] ^ d[13] ^ d[14] ^ d[15] ^ d[16] ^ d[17] ^
           d[18] ^ d[19] ^ d[21] ^ d[22] ^ d[23];
    return p;
  endfunction

endpackage

// ==== design/dphy_hs_data_rx.sv ====
module dphy_hs_data_rx import csi_rx_pkg::*; (
  input  logic  byte_clk_i,
  input  logic  rst_n_i,
  input  logic  bit_clk_i,
  input  logic  bit_clk_inv_i,
  input  logic  hs_en_i,
  input  logic  dphy_data_p_i,
  input  logic  dphy_data_n_i,
  output byte_t byte_data_o
);

  logic  serial_bit;
  logic  rst_d1;
  logic  rst_d2;
  logic  rise_bit;
  logic  fall_bit;
  byte_t shift_q;

  assign serial_bit = dphy_data_p_i & ~dphy_data_n_i;   // Differential receiver.

  ////////////////////////////////////////////////////////////////////////////
  // Serdes reset
  ////////////////////////////////////////////////////////////////////////////

  // Two stages in the bit clock, so only a few preamble bits are lost on release.
  always_ff @(posedge bit_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      rst_d1 <= 1'b1;
      rst_d2 <= 1'b1;
    end
    else
    begin
      rst_d1 <= ~hs_en_i;
      rst_d2 <= rst_d1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // DDR sampling
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge bit_clk_i)
  begin
    rise_bit <= serial_bit;                             // Earlier bit of each pair.
  end

  always_ff @(posedge bit_clk_inv_i)
  begin
    fall_bit <= serial_bit;
  end

  // Shifts right two bits per bit clock, first bit ends in bit 0.
  always_ff @(posedge bit_clk_i)
  begin
    if (rst_d2)
      shift_q <= '0;
    else
      shift_q <= {fall_bit, rise_bit, shift_q[7:2]};
  end

  // Four bit clocks per byte clock, so each capture holds eight fresh bits.
  always_ff @(posedge byte_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      byte_data_o <= '0;
    else
      byte_data_o <= shift_q;
  end

endmodule

// ==== design/dphy_byte_aligner.sv ====
module dphy_byte_aligner import csi_rx_pkg::*; (
  input  logic  byte_clk_i,
  input  logic  rst_n_i,
  input  logic  hs_en_i,
  input  byte_t byte_data_i,
  output byte_t al_byte_o,
  output logic  al_valid_o
);

  byte_t       prev_q;
  logic [15:0] window;
  logic        locked_q;
  bit_ofs_t    ofs_q;
  logic        hit;
  bit_ofs_t    hit_ofs;

  // Older byte in the low half, as bits arrive LSB first.
  assign window = {byte_data_i, prev_q};

  ////////////////////////////////////////////////////////////////////////////
  // Sync search
  ////////////////////////////////////////////////////////////////////////////

  // Scan from the top so the lowest matching offset wins.
  always_comb
  begin
    hit     = 1'b0;
    hit_ofs = '0;
    for (int i = 7; i >= 0; i--)
    begin
      if (window[i +: 8] == SYNC_BYTE)
      begin
        hit     = 1'b1;
        hit_ofs = bit_ofs_t'(i);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Lock and output
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge byte_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      prev_q     <= '0;
      locked_q   <= 1'b0;
      ofs_q      <= '0;
      al_valid_o <= 1'b0;
    end
    else if (!hs_en_i)
    begin
      prev_q     <= '0;                 // Unlock between bursts.
      locked_q   <= 1'b0;
      ofs_q      <= '0;
      al_valid_o <= 1'b0;
    end
    else
    begin
      prev_q <= byte_data_i;
      if (!locked_q && hit)
      begin
        locked_q <= 1'b1;
        ofs_q    <= hit_ofs;
      end
      al_valid_o <= locked_q;           // First data byte follows the sync window.
    end
  end

  // The byte after the sync sits at the same offset one window later.
  always_ff @(posedge byte_clk_i)
  begin
    if (locked_q)
      al_byte_o <= window[ofs_q +: 8];
  end

endmodule

// ==== design/dphy_lane_merger.sv ====
module dphy_lane_merger import csi_rx_pkg::*; (
  input  logic                 byte_clk_i,
  input  logic                 rst_n_i,
  input  logic                 hs_en_i,
  input  byte_t                al_byte_i [NUM_LANES],
  input  logic [NUM_LANES-1:0] al_valid_i,
  output word_t                mrg_word_o,
  output logic                 mrg_valid_o
);

  byte_t                fifo_mem [NUM_LANES][FIFO_DEPTH];
  logic [FIFO_PTR_W:0]  wr_ptr_q [NUM_LANES];   // Extra bit tells full from empty.
  logic [FIFO_PTR_W:0]  rd_ptr_q [NUM_LANES];
  logic [NUM_LANES-1:0] not_empty;
  logic                 pop;

  always_comb
  begin
    for (int i = 0; i < NUM_LANES; i++)
    begin
      not_empty[i] = wr_ptr_q[i] != rd_ptr_q[i];
    end
  end

  // The early lane waits here until the late one has a byte too.
  assign pop = &not_empty;

  ////////////////////////////////////////////////////////////////////////////
  // Deskew FIFOs
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge byte_clk_i)
  begin
    for (int i = 0; i < NUM_LANES; i++)
    begin
      if (al_valid_i[i])
        fifo_mem[i][wr_ptr_q[i][FIFO_PTR_W-1:0]] <= al_byte_i[i];
    end
  end

  always_ff @(posedge byte_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_q <= '{default: '0};
      rd_ptr_q <= '{default: '0};
    end
    else if (!hs_en_i)
    begin
      wr_ptr_q <= '{default: '0};     // Flush.
      rd_ptr_q <= '{default: '0};
    end
    else
    begin
      for (int i = 0; i < NUM_LANES; i++)
      begin
        if (al_valid_i[i])
          wr_ptr_q[i] <= wr_ptr_q[i] + 1'b1;
        if (pop)
          rd_ptr_q[i] <= rd_ptr_q[i] + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Merged word
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge byte_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      mrg_valid_o <= 1'b0;
    else
      mrg_valid_o <= hs_en_i & pop;
  end

  always_ff @(posedge byte_clk_i)
  begin
    if (pop)
    begin
      for (int i = 0; i < NUM_LANES; i++)
      begin
        mrg_word_o[i*8 +: 8] <= fifo_mem[i][rd_ptr_q[i][FIFO_PTR_W-1:0]];
      end
    end
  end

endmodule

// ==== design/csi_packet_parser.sv ====
module csi_packet_parser import csi_rx_pkg::*; (
  input  logic       byte_clk_i,
  input  logic       rst_n_i,
  input  logic       hs_en_i,
  input  logic       mrg_valid_i,
  input  word_t      mrg_word_i,
  output logic       pkt_start_o,
  output logic       hdr_err_o,
  output logic       pkt_end_o,
  output logic       pay_valid_o,
  output logic       pay_last_o,
  output vc_t        pkt_vc_o,
  output data_type_t pkt_dt_o,
  output word_cnt_t  pkt_wc_o,
  output word_t      pay_data_o,
  output logic [1:0] pay_keep_o
);

  parser_state_t state_q;
  byte_t         di_q;
  byte_t         wc_lo_q;
  word_cnt_t     bytes_left_q;
  logic          end_pend_q;
  logic [23:0]   hdr_bits;
  word_cnt_t     wc_rx;
  logic          ecc_ok;
  logic          is_short;

  // Header word 0 is {wc_lo, data_id}, word 1 is {ecc, wc_hi}.
  assign hdr_bits = {mrg_word_i[7:0], wc_lo_q, di_q};
  assign wc_rx    = {mrg_word_i[7:0], wc_lo_q};
  assign ecc_ok   = csi_ecc(hdr_bits) == mrg_word_i[13:8];
  assign is_short = di_q[5:0] <= SHORT_DT_MAX;

  ////////////////////////////////////////////////////////////////////////////
  // Packet FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge byte_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_q      <= IDLE;
      bytes_left_q <= '0;
      end_pend_q   <= 1'b0;
      pkt_start_o  <= 1'b0;
      hdr_err_o    <= 1'b0;
      pkt_end_o    <= 1'b0;
      pay_valid_o  <= 1'b0;
      pay_last_o   <= 1'b0;
      pay_keep_o   <= '0;
    end
    else
    begin
      pkt_start_o <= 1'b0;              // Strobes default low.
      hdr_err_o   <= 1'b0;
      pkt_end_o   <= 1'b0;
      pay_valid_o <= 1'b0;
      pay_last_o  <= 1'b0;
      pay_keep_o  <= '0;
      if (!hs_en_i)
      begin
        state_q    <= IDLE;
        end_pend_q <= 1'b0;
      end
      else
      begin
        case (state_q)
          IDLE:
            state_q <= HDR0;
          HDR0:
            if (mrg_valid_i)
              state_q <= HDR1;
          HDR1:
            if (mrg_valid_i)
            begin
              if (!ecc_ok)
              begin
                hdr_err_o <= 1'b1;
                state_q   <= DONE;
              end
              else if (is_short)
              begin
                pkt_start_o <= 1'b1;
                end_pend_q  <= 1'b1;
                state_q     <= DONE;
              end
              else
              begin
                pkt_start_o  <= 1'b1;
                bytes_left_q <= wc_rx;
                state_q      <= (wc_rx == '0) ? FOOTER : PAYLOAD;
              end
            end
          PAYLOAD:
            if (mrg_valid_i)
            begin
              pay_valid_o <= 1'b1;
              if (bytes_left_q <= word_cnt_t'(2))
              begin
                pay_last_o   <= 1'b1;
                pay_keep_o   <= (bytes_left_q == word_cnt_t'(1)) ? 2'b01 : 2'b11;
                bytes_left_q <= '0;
                state_q      <= FOOTER;
              end
              else
              begin
                pay_keep_o   <= 2'b11;
                bytes_left_q <= bytes_left_q - word_cnt_t'(2);
              end
            end
          // On odd counts footer byte 0 rode in the last payload word, so one word ends it.
          FOOTER:
            if (mrg_valid_i)
            begin
              pkt_end_o <= 1'b1;
              state_q   <= DONE;
            end
          DONE:
            if (end_pend_q)
            begin
              pkt_end_o  <= 1'b1;       // Short packet end.
              end_pend_q <= 1'b0;
            end
          default:
            state_q <= IDLE;
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Header fields and payload data
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge byte_clk_i)
  begin
    if (state_q == HDR0 && mrg_valid_i)
    begin
      di_q    <= mrg_word_i[7:0];
      wc_lo_q <= mrg_word_i[15:8];
    end
    if (state_q == HDR1 && mrg_valid_i)
    begin
      pkt_vc_o <= di_q[7:6];
      pkt_dt_o <= di_q[5:0];
      pkt_wc_o <= wc_rx;
    end
    if (state_q == PAYLOAD && mrg_valid_i)
    begin
      if (bytes_left_q == word_cnt_t'(1))
        pay_data_o <= {8'h00, mrg_word_i[7:0]};   // Hide the footer byte.
      else
        pay_data_o <= mrg_word_i;
    end
  end

endmodule

// ==== design/csi_rx_top.sv ====
module csi_rx_top import csi_rx_pkg::*; (
  input  logic                 byte_clk_i,
  input  logic                 rst_n_i,
  input  logic                 bit_clk_i,
  input  logic                 bit_clk_inv_i,
  input  logic                 hs_en_i,
  input  logic [NUM_LANES-1:0] dphy_data_p_i,
  input  logic [NUM_LANES-1:0] dphy_data_n_i,
  output logic                 pkt_start_o,
  output logic                 hdr_err_o,
  output logic                 pkt_end_o,
  output vc_t                  pkt_vc_o,
  output data_type_t           pkt_dt_o,
  output word_cnt_t            pkt_wc_o,
  output word_t                pay_data_o,
  output logic                 pay_valid_o,
  output logic [1:0]           pay_keep_o,
  output logic                 pay_last_o
);

  byte_t                lane_byte [NUM_LANES];
  byte_t                al_byte   [NUM_LANES];
  logic [NUM_LANES-1:0] al_valid;
  word_t                mrg_word;
  logic                 mrg_valid;

  for (genvar i = 0; i < NUM_LANES; i++)
  begin : g_lane
    dphy_hs_data_rx u_hs_rx (
      .byte_clk_i    ( byte_clk_i       ),
      .rst_n_i       ( rst_n_i          ),
      .bit_clk_i     ( bit_clk_i        ),
      .bit_clk_inv_i ( bit_clk_inv_i    ),
      .hs_en_i       ( hs_en_i          ),
      .dphy_data_p_i ( dphy_data_p_i[i] ),
      .dphy_data_n_i ( dphy_data_n_i[i] ),
      .byte_data_o   ( lane_byte[i]     )
    );

    dphy_byte_aligner u_aligner (
      .byte_clk_i    ( byte_clk_i       ),
      .rst_n_i       ( rst_n_i          ),
      .hs_en_i       ( hs_en_i          ),
      .byte_data_i   ( lane_byte[i]     ),
      .al_byte_o     ( al_byte[i]       ),
      .al_valid_o    ( al_valid[i]      )
    );
  end

  dphy_lane_merger u_merger (
    .byte_clk_i  ( byte_clk_i ),
    .rst_n_i     ( rst_n_i    ),
    .hs_en_i     ( hs_en_i    ),
    .al_byte_i   ( al_byte    ),
    .al_valid_i  ( al_valid   ),
    .mrg_word_o  ( mrg_word   ),
    .mrg_valid_o ( mrg_valid  )
  );

  csi_packet_parser u_parser (
    .byte_clk_i  ( byte_clk_i  ),
    .rst_n_i     ( rst_n_i     ),
    .hs_en_i     ( hs_en_i     ),
    .mrg_valid_i ( mrg_valid   ),
    .mrg_word_i  ( mrg_word    ),
    .pkt_start_o ( pkt_start_o ),
    .hdr_err_o   ( hdr_err_o   ),
    .pkt_end_o   ( pkt_end_o   ),
    .pay_valid_o ( pay_valid_o ),
    .pay_last_o  ( pay_last_o  ),
    .pkt_vc_o    ( pkt_vc_o    ),
    .pkt_dt_o    ( pkt_dt_o    ),
    .pkt_wc_o    ( pkt_wc_o    ),
    .pay_data_o  ( pay_data_o  ),
    .pay_keep_o  ( pay_keep_o  )
  );

endmodule

// ==== test/csi_rx_tb.sv ====
module csi_rx_tb import csi_rx_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_BURSTS = 24;
  localparam int TIMEOUT    = 200;

  // Syndrome column of each header bit, bit 0 in the low six bits.
  localparam logic [143:0] ECC_COLS = {
    6'h3B, 6'h37, 6'h2F, 6'h1F, 6'h38, 6'h34, 6'h32, 6'h31,
    6'h2C, 6'h2A, 6'h29, 6'h26, 6'h25, 6'h23, 6'h1C, 6'h1A,
    6'h19, 6'h16, 6'h15, 6'h13, 6'h0E, 6'h0D, 6'h0B, 6'h07
  };

  typedef struct packed {
    logic       start;
    logic       err;
    logic       fin;
    logic       pay;
    logic       last;
    logic [1:0] keep;
    vc_t        vc;
    data_type_t dt;
    word_cnt_t  wc;
    word_t      data;
  } event_t;

  logic       byte_clk_i    = 1'b0;
  logic       rst_n_i;
  logic       bit_clk_i     = 1'b0;
  logic       bit_clk_inv_i = 1'b1;
  logic       hs_en_i;
  logic [1:0] dphy_data_p_i;
  logic [1:0] dphy_data_n_i;
  logic       pkt_start_o;
  logic       hdr_err_o;
  logic       pkt_end_o;
  vc_t        pkt_vc_o;
  data_type_t pkt_dt_o;
  word_cnt_t  pkt_wc_o;
  word_t      pay_data_o;
  logic       pay_valid_o;
  logic [1:0] pay_keep_o;
  logic       pay_last_o;

  event_t     exp_q [$];
  logic [1:0] bit_q [$];                         // One bit per lane per bit time.
  byte_t      pkt_bytes [$];
  logic       lanes_busy;

  csi_rx_top DUT (
    .byte_clk_i    ( byte_clk_i    ),
    .rst_n_i       ( rst_n_i       ),
    .bit_clk_i     ( bit_clk_i     ),
    .bit_clk_inv_i ( bit_clk_inv_i ),
    .hs_en_i       ( hs_en_i       ),
    .dphy_data_p_i ( dphy_data_p_i ),
    .dphy_data_n_i ( dphy_data_n_i ),
    .pkt_start_o   ( pkt_start_o   ),
    .hdr_err_o     ( hdr_err_o     ),
    .pkt_end_o     ( pkt_end_o     ),
    .pkt_vc_o      ( pkt_vc_o      ),
    .pkt_dt_o      ( pkt_dt_o      ),
    .pkt_wc_o      ( pkt_wc_o      ),
    .pay_data_o    ( pay_data_o    ),
    .pay_valid_o   ( pay_valid_o   ),
    .pay_keep_o    ( pay_keep_o    ),
    .pay_last_o    ( pay_last_o    )
  );

  // Byte clock edges fall on bit_clk_i falling edges.
  initial
  begin
    forever
    begin
      for (int k = 0; k < 8; k++)
      begin
        #1;
        bit_clk_i     = ~bit_clk_i;
        bit_clk_inv_i = ~bit_clk_inv_i;
        if (k == 3 || k == 7)
          byte_clk_i = ~byte_clk_i;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checking helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic compare_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
    if (act_v !== exp_v)
    begin
      $display("ERR %0t %s expected %0h actual %0h", $time, name, exp_v, act_v);
      $display("TEST FAIL");
      $fatal(1);
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  function automatic ecc_t header_ecc(input logic [23:0] hdr);
    ecc_t e;
    e = '0;
    for (int i = 0; i < 24; i++)
    begin
      if (hdr[i])
        e = e ^ ECC_COLS[i*6 +: 6];
    end
    return e;
  endfunction

  task automatic expect_quiet(input int cycles);
    repeat (cycles)
    begin
      @(negedge byte_clk_i);
      compare_value("pkt_start_o", 0, pkt_start_o);
      compare_value("hdr_err_o", 0, hdr_err_o);
      compare_value("pkt_end_o", 0, pkt_end_o);
      compare_value("pay_valid_o", 0, pay_valid_o);
      compare_value("pay_last_o", 0, pay_last_o);
      compare_value("pay_keep_o", 0, pay_keep_o);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Burst generation and lane bits
  ////////////////////////////////////////////////////////////////////////////

  task automatic build_burst(input int burst);
    int           kind;
    int           flip;
    int           late;
    int           pos;
    int           nbits;
    int           zeros [2];
    int           skew [2];
    data_type_t   dt;
    vc_t          vc;
    word_cnt_t    wc;
    byte_t        ecc_byte;
    event_t       ev;
    logic [511:0] lane_bits [2];
    kind = (burst % 5 == 3) ? 2 : (($urandom_range(2) == 0) ? 1 : 0);  // 1 short, 2 bad ECC.
    vc   = $urandom_range(3);
    dt   = (kind == 1) ? $urandom_range(15) : $urandom_range(63, 16);
    wc   = (kind == 1) ? $urandom : $urandom_range(40);
    ecc_byte = {2'b00, header_ecc({wc, vc, dt})};
    if (kind == 2)
    begin
      flip = $urandom_range(5);
      ecc_byte[flip] = ~ecc_byte[flip];
    end
    pkt_bytes = {};
    pkt_bytes.push_back({vc, dt});
    pkt_bytes.push_back(wc[7:0]);
    pkt_bytes.push_back(wc[15:8]);
    pkt_bytes.push_back(ecc_byte);
    ev     = '0;
    ev.err = (kind == 2);
    if (kind != 2)
    begin
      ev.start = 1'b1;
      ev.vc    = vc;
      ev.dt    = dt;
      ev.wc    = wc;
    end
    exp_q.push_back(ev);
    if (kind == 0)
    begin
      for (int i = 0; i < wc; i++)
        pkt_bytes.push_back($urandom);
      for (int i = 0; i < wc; i += 2)
      begin
        ev      = '0;
        ev.pay  = 1'b1;
        ev.last = (i + 2 >= wc);
        ev.keep = (i + 1 < wc) ? 2'b11 : 2'b01;
        ev.data = (i + 1 < wc) ? {pkt_bytes[5+i], pkt_bytes[4+i]} : {8'h00, pkt_bytes[4+i]};
        exp_q.push_back(ev);
      end
    end
    if (kind != 2)
    begin
      ev     = '0;
      ev.fin = 1'b1;
      exp_q.push_back(ev);
    end
    for (int i = 0; i < 10; i++)
      pkt_bytes.push_back($urandom);             // Footer and trailing bytes.
    // Lane 0 walks through all eight bit offsets over the bursts.
    zeros[0] = 8 + burst % 8;
    zeros[1] = $urandom_range(15, 8);
    late     = $urandom_range(1);
    skew[0]  = 0;
    skew[1]  = 0;
    skew[late] = $urandom_range(3);
    if (skew[late] * 8 + zeros[late] - zeros[1 - late] > 24)
      skew[late] = 2;                            // Keep the lock skew within 3 bytes.
    nbits = 0;
    for (int ln = 0; ln < 2; ln++)
    begin
      lane_bits[ln] = '0;
      pos = zeros[ln] + 8 * skew[ln];
      lane_bits[ln][pos +: 8] = SYNC_BYTE;
      pos = pos + 8;
      for (int i = ln; i < pkt_bytes.size(); i += 2)
      begin
        lane_bits[ln][pos +: 8] = pkt_bytes[i];
        pos = pos + 8;
      end
      if (pos > nbits)
        nbits = pos;
    end
    bit_q = {};
    for (int i = 0; i < nbits + 16; i++)
      bit_q.push_back({lane_bits[1][i], lane_bits[0][i]});
  endtask

  // A quarter bit after each bit clock edge, LSB of each byte first.
  task automatic drive_lanes();
    logic [1:0] b;
    while (bit_q.size() > 0)
    begin
      @(bit_clk_i);
      #0.25;
      b = bit_q.pop_front();
      dphy_data_p_i = b;
      dphy_data_n_i = ~b;
    end
    lanes_busy = 1'b0;
  endtask

  task automatic check_events();
    event_t ev;
    int     waited;
    while (exp_q.size() > 0)
    begin
      waited = 0;
      do
      begin
        @(negedge byte_clk_i);
        waited++;
        if (waited > TIMEOUT)
          abort_run("An expected output strobe did not arrive within 200 byte cycles.");
      end
      while (!(pkt_start_o || hdr_err_o || pkt_end_o || pay_valid_o));
      ev = exp_q.pop_front();
      compare_value("pkt_start_o", ev.start, pkt_start_o);
      compare_value("hdr_err_o", ev.err, hdr_err_o);
      compare_value("pkt_end_o", ev.fin, pkt_end_o);
      compare_value("pay_valid_o", ev.pay, pay_valid_o);
      if (ev.start)
      begin
        compare_value("pkt_vc_o", ev.vc, pkt_vc_o);
        compare_value("pkt_dt_o", ev.dt, pkt_dt_o);
        compare_value("pkt_wc_o", ev.wc, pkt_wc_o);
      end
      if (ev.pay)
      begin
        compare_value("pay_data_o", ev.data, pay_data_o);
        compare_value("pay_keep_o", ev.keep, pay_keep_o);
        compare_value("pay_last_o", ev.last, pay_last_o);
      end
    end
    // Rest of the burst carries no further strobes.
    waited = 0;
    while (lanes_busy)
    begin
      expect_quiet(1);
      waited++;
      if (waited > TIMEOUT)
        abort_run("The lane bit driver did not finish within 200 byte cycles.");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    void'($urandom(32'ha244c43e));
    rst_n_i       = 1'b0;
    hs_en_i       = 1'b0;
    dphy_data_p_i = 2'b00;
    dphy_data_n_i = 2'b11;
    lanes_busy    = 1'b0;
    expect_quiet(5);                             // Outputs held low in reset.
    rst_n_i = 1'b1;
    expect_quiet(5);
    for (int b = 0; b < NUM_BURSTS; b++)
    begin
      build_burst(b);
      hs_en_i    = 1'b1;
      lanes_busy = 1'b1;
      fork
        drive_lanes();
        check_events();
      join
      expect_quiet(4);
      hs_en_i = 1'b0;
      expect_quiet(6);
    end
    $display("TEST PASS");
    $finish;
  end

endmodule

// ==== project.f ====
design/csi_rx_pkg.sv
design/dphy_hs_data_rx.sv
design/dphy_byte_aligner.sv
design/dphy_lane_merger.sv
design/csi_packet_parser.sv
design/csi_rx_top.sv
test/csi_rx_tb.sv

// ==== Bender.yml ====
package:
  name: csi_rx

sources:
  - design/csi_rx_pkg.sv
  - design/dphy_hs_data_rx.sv
  - design/dphy_byte_aligner.sv
  - design/dphy_lane_merger.sv
  - design/csi_packet_parser.sv
  - design/csi_rx_top.sv
  - target: test
    files:
      - test/csi_rx_tb.sv
